// ==== vlog.f ====
+incdir+include
hw/csi2_stat_pkg.sv
hw/csi2_err_counter.sv
hw/csi2_geom_tracker.sv
hw/freq_meas.sv
hw/csi2_stat_acc.sv
dv/csi2_stat_tb.sv

// ==== Makefile ====
# Verilator build and run of the CSI-2 statistics testbench

TOP = csi2_stat_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -o sim

run: compile
	./obj_dir/sim

clean:
	rm -rf obj_dir

// ==== dv/csi2_stat_tb.sv ====
/*
  Testbench for the CSI-2 receiver statistics block.
  Random lines, frames and error bursts against a reference model,
  then the clear and the byte clock measurement.
*/
`timescale 1ns/10ps

`include "csi2_stat_macros.svh"

module csi2_stat_tb;

localparam int REF_CLK_FREQ   = 1000;
// Three meter gates plus margin for the stimulus
localparam int TIMEOUT_CYCLES = 6000;
// Second gate ends about two reference cycles after REF_CLK_FREQ * 2
localparam int FREQ_WAIT      = 2 * REF_CLK_FREQ + 10;

logic                           clk_i;
logic                           rst_i;
logic                           dphy_byte_clk_i;
logic                           clear_stat_i;
csi2_stat_pkg::csi2_video_ev_t  video_i;
csi2_stat_pkg::csi2_err_ev_t    err_i;
csi2_stat_pkg::csi2_err_stat_t  err_stat_o;
csi2_stat_pkg::csi2_geom_stat_t geom_stat_o;
logic [`CSI2_STAT_W-1:0]        dphy_byte_freq_o;

// Reference model state
csi2_stat_pkg::csi2_err_stat_t  m_err;
csi2_stat_pkg::csi2_geom_stat_t m_geom;
csi2_stat_pkg::csi2_err_ev_t    err_d1;
csi2_stat_pkg::csi2_err_ev_t    err_d2;
logic [31:0]                    m_px;
logic [31:0]                    m_ln;
logic [31:0]                    line_len;
logic                           m_seen;
logic                           accepted;
logic                           is_start;
logic                           is_eol;

logic [31:0] lfsr_q = 32'hf0d3_9971;
string       test_name = "reset";
int          cycle_cnt = 0;
int          release_cycle = 0;

csi2_stat_acc #(
  .REF_CLK_FREQ ( REF_CLK_FREQ )
) i_csi2_stat_acc (
  .clk_i            ( clk_i            ),
  .rst_i            ( rst_i            ),
  .video_i          ( video_i          ),
  .err_i            ( err_i            ),
  .clear_stat_i     ( clear_stat_i     ),
  .dphy_byte_clk_i  ( dphy_byte_clk_i  ),
  .err_stat_o       ( err_stat_o       ),
  .geom_stat_o      ( geom_stat_o      ),
  .dphy_byte_freq_o ( dphy_byte_freq_o )
);

initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

// Byte clock at 40 MHz
initial
  begin
    dphy_byte_clk_i = 1'b0;
    forever #12.5 dphy_byte_clk_i = ~dphy_byte_clk_i;
  end

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] take_bits(input int n);
  logic [31:0] b;
  b = '0;
  for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      b = {b[30:0], lfsr_q[0]};
    end
  return b;
endfunction

task automatic end_with_failure(input string reason);
  $display("%s", reason);
  $display("Simulation failed");
  $fatal(1, "run stopped at the first failure");
endtask

task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
  assert (actual === expected)
  else
    end_with_failure($sformatf("mismatch %s %s: expected 0x%h, actual 0x%h",
                               test_name, what, expected, actual));
endtask

always @(posedge clk_i)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      end_with_failure($sformatf("timeout: run not finished after %0d clock cycles",
                                 TIMEOUT_CYCLES));
  end

// Reference model, follows the counting rules edge by edge
always @(posedge clk_i or posedge rst_i)
  if (rst_i)
    begin
      m_err                 = '0;
      m_geom.max_px_per_ln    = '0;
      m_geom.min_px_per_ln    = '1;
      m_geom.max_ln_per_frame = '0;
      m_geom.min_ln_per_frame = '1;
      err_d1                = '0;
      err_d2                = '0;
      m_px                  = '0;
      m_ln                  = '0;
      m_seen                = 1'b0;
    end
  else
    begin
      // Error level sampled two edges ago reaches the counts now
      if (clear_stat_i)
        m_err = '0;
      else
        begin
          if (err_d2.header_err)
            m_err.header_err_cnt = m_err.header_err_cnt + 1;
          if (err_d2.header_err && err_d2.corr_header_err)
            m_err.corr_header_err_cnt = m_err.corr_header_err_cnt + 1;
          if (err_d2.crc_err)
            m_err.crc_err_cnt = m_err.crc_err_cnt + 1;
        end
      err_d2 = err_d1;
      err_d1 = err_i;

      accepted = video_i.val && video_i.ready;
      is_start = accepted && video_i.frame_start;
      is_eol   = accepted && video_i.eol && !video_i.frame_start;
      line_len = m_px + 1;
      if (clear_stat_i)
        begin
          m_geom.max_px_per_ln    = '0;
          m_geom.min_px_per_ln    = '1;
          m_geom.max_ln_per_frame = '0;
          m_geom.min_ln_per_frame = '1;
        end
      else
        begin
          if (is_eol && line_len > m_geom.max_px_per_ln)
            m_geom.max_px_per_ln = line_len;
          if (is_eol && line_len < m_geom.min_px_per_ln)
            m_geom.min_px_per_ln = line_len;
          // Only a frame opened by an earlier start counts
          if (is_start && m_seen && m_ln > m_geom.max_ln_per_frame)
            m_geom.max_ln_per_frame = m_ln;
          if (is_start && m_seen && m_ln < m_geom.min_ln_per_frame)
            m_geom.min_ln_per_frame = m_ln;
        end

      if (is_eol)
        m_px = '0;
      else if (accepted)
        m_px = m_px + 1;
      if (is_start)
        m_ln = '0;
      else if (is_eol)
        m_ln = m_ln + 1;
      m_seen = clear_stat_i ? is_start : (m_seen || is_start);
    end

// Outputs are registered, so they are stable on the falling edge
always @(negedge clk_i)
  if (!rst_i)
    begin
      check_value("header_err_cnt", m_err.header_err_cnt, err_stat_o.header_err_cnt);
      check_value("corr_header_err_cnt", m_err.corr_header_err_cnt,
                  err_stat_o.corr_header_err_cnt);
      check_value("crc_err_cnt", m_err.crc_err_cnt, err_stat_o.crc_err_cnt);
      check_value("max_px_per_ln", m_geom.max_px_per_ln, geom_stat_o.max_px_per_ln);
      check_value("min_px_per_ln", m_geom.min_px_per_ln, geom_stat_o.min_px_per_ln);
      check_value("max_ln_per_frame", m_geom.max_ln_per_frame, geom_stat_o.max_ln_per_frame);
      check_value("min_ln_per_frame", m_geom.min_ln_per_frame, geom_stat_o.min_ln_per_frame);
    end

task automatic check_reset_values();
  check_value("header_err_cnt", 32'h0, err_stat_o.header_err_cnt);
  check_value("corr_header_err_cnt", 32'h0, err_stat_o.corr_header_err_cnt);
  check_value("crc_err_cnt", 32'h0, err_stat_o.crc_err_cnt);
  check_value("max_px_per_ln", 32'h0, geom_stat_o.max_px_per_ln);
  check_value("min_px_per_ln", 32'hffff_ffff, geom_stat_o.min_px_per_ln);
  check_value("max_ln_per_frame", 32'h0, geom_stat_o.max_ln_per_frame);
  check_value("min_ln_per_frame", 32'hffff_ffff, geom_stat_o.min_ln_per_frame);
endtask

task automatic drive_video(input logic val, input logic ready, input logic eol,
                           input logic fs);
  @(negedge clk_i);
  video_i.val         = val;
  video_i.ready       = ready;
  video_i.eol         = eol;
  video_i.frame_start = fs;
endtask

task automatic idle(input int n);
  repeat (n)
    drive_video(1'b0, 1'b0, 1'b0, 1'b0);
endtask

// Cycles without an accepted beat, with random eol and frame_start
task automatic send_gaps();
  logic [31:0] r;
  while (take_bits(2) == 3)
    begin
      r = take_bits(3);
      drive_video(r[2], !r[2], r[1], r[0]);
    end
endtask

task automatic send_line(input int len, input bit first);
  for (int p = 0; p < len; p++)
    begin
      send_gaps();
      drive_video(1'b1, 1'b1, p == len - 1, first && p == 0);
    end
endtask

task automatic send_frame(output int lines);
  int n;
  int len;
  n = take_bits(3) + 1;
  lines = 0;
  for (int l = 0; l < n; l++)
    begin
      len = take_bits(4) + 1;
      send_line(len, l == 0);
      // A one-pixel first line ends on the frame start beat, which closes no line
      if (!(l == 0 && len == 1))
        lines++;
    end
endtask

task automatic send_err_burst(input logic [2:0] pattern, input int hold, input int gap);
  repeat (hold)
    begin
      @(negedge clk_i);
      err_i = pattern;
    end
  repeat (gap)
    begin
      @(negedge clk_i);
      err_i = '0;
    end
endtask

initial
  begin
    int          lines;
    logic [31:0] r;
    rst_i        = 1'b1;
    clear_stat_i = 1'b0;
    video_i      = '0;
    err_i        = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    release_cycle = cycle_cnt;
    check_reset_values();
    check_value("dphy_byte_freq_o", 32'h0, dphy_byte_freq_o);

    test_name = "errors";
    // Corrected header alone, then CRC alone, then both header strobes
    send_err_burst(3'b010, 3, 2);
    send_err_burst(3'b001, 2, 2);
    send_err_burst(3'b110, 4, 3);
    repeat (20)
      begin
        r = take_bits(8);
        send_err_burst(r[2:0], r[4:3] + 2, r[6:5] + 1);
      end
    idle(4);

    test_name = "lines";
    // No frame start yet, so these lines build no frame
    repeat (12)
      send_line(take_bits(4) + 1, 1'b0);
    idle(2);

    test_name = "frames";
    repeat (10)
      send_frame(lines);
    drive_video(1'b1, 1'b1, 1'b0, 1'b1);
    idle(2);

    test_name = "clear";
    @(negedge clk_i);
    clear_stat_i = 1'b1;
    @(negedge clk_i);
    clear_stat_i = 1'b0;
    check_reset_values();
    send_frame(lines);
    drive_video(1'b1, 1'b1, 1'b0, 1'b1);
    idle(2);
    check_value("max_ln_per_frame", lines, geom_stat_o.max_ln_per_frame);
    check_value("min_ln_per_frame", lines, geom_stat_o.min_ln_per_frame);

    test_name = "frequency";
    while (cycle_cnt < release_cycle + FREQ_WAIT)
      @(negedge clk_i);
    assert (dphy_byte_freq_o >= 798 && dphy_byte_freq_o <= 802)
    else
      end_with_failure($sformatf("mismatch %s dphy_byte_freq_o: expected 798 to 802, actual %0d",
                                 test_name, dphy_byte_freq_o));

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== hw/csi2_stat_acc.sv ====
/*
  CSI-2 receiver statistics.
  Error counts, line and frame size extremes, and the D-PHY byte clock frequency,
  all reported in the pixel clock domain.
*/
`timescale 1ns/10ps

`include "csi2_stat_macros.svh"

module csi2_stat_acc #(
  parameter int unsigned REF_CLK_FREQ = `CSI2_REF_CLK_FREQ
)(
  input                                  clk_i,
  input                                  rst_i,
  input  csi2_stat_pkg::csi2_video_ev_t  video_i,
  input  csi2_stat_pkg::csi2_err_ev_t    err_i,
  input                                  clear_stat_i,
  input                                  dphy_byte_clk_i,
  output csi2_stat_pkg::csi2_err_stat_t  err_stat_o,
  output csi2_stat_pkg::csi2_geom_stat_t geom_stat_o,
  output logic [`CSI2_STAT_W-1:0]        dphy_byte_freq_o
);

// Error strobes arrive from the receive clock domain
csi2_err_counter err_counter
(
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .err_i        ( err_i        ),
  .clear_stat_i ( clear_stat_i ),
  .err_stat_o   ( err_stat_o   )
);

csi2_geom_tracker geom_tracker
(
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .video_i      ( video_i      ),
  .clear_stat_i ( clear_stat_i ),
  .geom_stat_o  ( geom_stat_o  )
);

// Pixel clock is the reference for the byte clock measurement
freq_meas #(
  .REF_CLK_FREQ ( REF_CLK_FREQ     )
) dphy_byte_clk_meas (
  .meas_clk_i   ( dphy_byte_clk_i  ),
  .ref_clk_i    ( clk_i            ),
  .rst_i        ( rst_i            ),
  .freq_o       ( dphy_byte_freq_o )
);

endmodule

// ==== hw/freq_meas.sv ====
/*
  Clock frequency meter.
  Counts edges of a measured clock over a gate of REF_CLK_FREQ reference
  cycles, so the result reads in Hz. The count crosses in Gray code.
*/
`timescale 1ns/10ps

`include "csi2_stat_macros.svh"

module freq_meas #(
  parameter int unsigned REF_CLK_FREQ = `CSI2_REF_CLK_FREQ
)(
  input                           meas_clk_i,
  input                           ref_clk_i,
  input                           rst_i,
  output logic [`CSI2_STAT_W-1:0] freq_o
);

localparam int GATE_W = ( REF_CLK_FREQ > 1 ) ? $clog2( REF_CLK_FREQ ) : 1;

function automatic logic [`CSI2_STAT_W-1:0] gray2bin( input logic [`CSI2_STAT_W-1:0] g );
  logic [`CSI2_STAT_W-1:0] b;
  b[`CSI2_STAT_W-1] = g[`CSI2_STAT_W-1];
  for( int i = `CSI2_STAT_W - 2; i >= 0; i-- )
    b[i] = b[i + 1] ^ g[i];
  return b;
endfunction

logic [1:0]              meas_rst_q;
logic [1:0]              ref_rst_q;
logic [`CSI2_STAT_W-1:0] meas_bin;
logic [`CSI2_STAT_W-1:0] meas_bin_next;
logic [`CSI2_STAT_W-1:0] meas_gray;
logic [`CSI2_STAT_W-1:0] gray_s1;
logic [`CSI2_STAT_W-1:0] gray_s2;
logic [`CSI2_STAT_W-1:0] ref_bin;
logic [`CSI2_STAT_W-1:0] prev_bin;
logic [GATE_W-1:0]       gate_cnt;
logic                    gate_end;

// Reset asserts at once and releases in step with each clock
always_ff @( posedge meas_clk_i, posedge rst_i )
  if( rst_i )
    meas_rst_q <= '1;
  else
    meas_rst_q <= { meas_rst_q[0], 1'b0 };

always_ff @( posedge ref_clk_i, posedge rst_i )
  if( rst_i )
    ref_rst_q <= '1;
  else
    ref_rst_q <= { ref_rst_q[0], 1'b0 };

// Measured domain: binary edge counter with a registered Gray mirror
assign meas_bin_next = meas_bin + 1'b1;

always_ff @( posedge meas_clk_i, posedge meas_rst_q[1] )
  if( meas_rst_q[1] )
    begin
      meas_bin  <= '0;
      meas_gray <= '0;
    end
  else
    begin
      meas_bin  <= meas_bin_next;
      meas_gray <= meas_bin_next ^ ( meas_bin_next >> 1 );
    end

// Reference domain: only one Gray bit changes per edge, so a sample is off by one at most
always_ff @( posedge ref_clk_i, posedge ref_rst_q[1] )
  if( ref_rst_q[1] )
    begin
      gray_s1 <= '0;
      gray_s2 <= '0;
    end
  else
    begin
      gray_s1 <= meas_gray;
      gray_s2 <= gray_s1;
    end

assign ref_bin  = gray2bin( gray_s2 );
assign gate_end = ( gate_cnt == GATE_W'( REF_CLK_FREQ - 1 ) );

always_ff @( posedge ref_clk_i, posedge ref_rst_q[1] )
  if( ref_rst_q[1] )
    begin
      gate_cnt <= '0;
      prev_bin <= '0;
      freq_o   <= '0;
    end
  else
    if( gate_end )
      begin
        gate_cnt <= '0;
        prev_bin <= ref_bin;
        freq_o   <= ref_bin - prev_bin;
      end
    else
      gate_cnt <= gate_cnt + 1'b1;

endmodule

// ==== hw/csi2_geom_tracker.sv ====
/*
  CSI-2 frame geometry tracker.
  Counts pixels per line and lines per frame on the pixel bus
  and keeps the largest and smallest values seen.
*/
`timescale 1ns/10ps

`include "csi2_stat_macros.svh"

module csi2_geom_tracker
(
  input                                  clk_i,
  input                                  rst_i,
  input  csi2_stat_pkg::csi2_video_ev_t  video_i,
  input                                  clear_stat_i,
  output csi2_stat_pkg::csi2_geom_stat_t geom_stat_o
);

logic                    beat;
logic                    line_end;
logic                    frame_start;
logic                    frame_end;
logic [`CSI2_STAT_W-1:0] px_cnt;
logic [`CSI2_STAT_W-1:0] px_next;
logic [`CSI2_STAT_W-1:0] ln_cnt;
logic                    frame_seen;

csi2_stat_pkg::csi2_geom_stat_t geom_stat_q;

assign beat        = video_i.val && video_i.ready;
assign frame_start = beat && video_i.frame_start;
// The first beat of a frame never closes a line
assign line_end    = beat && video_i.eol && !video_i.frame_start;
// A frame is complete only when an earlier frame start opened it
assign frame_end   = frame_start && frame_seen;
assign px_next     = px_cnt + 1'b1;

// Running pixel counter, restarts after each line end
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    px_cnt <= '0;
  else
    if( line_end )
      px_cnt <= '0;
    else
      if( beat )
        px_cnt <= px_next;

// Running line counter, restarts at each frame start
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    ln_cnt <= '0;
  else
    if( frame_start )
      ln_cnt <= '0;
    else
      if( line_end )
        ln_cnt <= ln_cnt + 1'b1;

// Clear drops the open frame, unless a new one starts in the same cycle
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    frame_seen <= 1'b0;
  else
    if( clear_stat_i )
      frame_seen <= frame_start;
    else
      if( frame_start )
        frame_seen <= 1'b1;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      geom_stat_q.max_px_per_ln    <= '0;
      geom_stat_q.min_px_per_ln    <= '1;
      geom_stat_q.max_ln_per_frame <= '0;
      geom_stat_q.min_ln_per_frame <= '1;
    end
  else
    if( clear_stat_i )
      begin
        geom_stat_q.max_px_per_ln    <= '0;
        geom_stat_q.min_px_per_ln    <= '1;
        geom_stat_q.max_ln_per_frame <= '0;
        geom_stat_q.min_ln_per_frame <= '1;
      end
    else
      begin
        // Line length includes the eol beat itself
        if( line_end && ( px_next > geom_stat_q.max_px_per_ln ) )
          geom_stat_q.max_px_per_ln <= px_next;
        if( line_end && ( px_next < geom_stat_q.min_px_per_ln ) )
          geom_stat_q.min_px_per_ln <= px_next;

        if( frame_end && ( ln_cnt > geom_stat_q.max_ln_per_frame ) )
          geom_stat_q.max_ln_per_frame <= ln_cnt;
        if( frame_end && ( ln_cnt < geom_stat_q.min_ln_per_frame ) )
          geom_stat_q.min_ln_per_frame <= ln_cnt;
      end

assign geom_stat_o = geom_stat_q;

endmodule

// ==== hw/csi2_err_counter.sv ====
/*
  CSI-2 error counter.
  Brings the decoder error strobes into the pixel clock domain and counts them.
*/
`timescale 1ns/10ps

`include "csi2_stat_macros.svh"

module csi2_err_counter
(
  input                               clk_i,
  input                               rst_i,
  input  csi2_stat_pkg::csi2_err_ev_t err_i,
  input                               clear_stat_i,
  output csi2_stat_pkg::csi2_err_stat_t err_stat_o
);

// Synchronizer chain, all three strobes travel together
csi2_stat_pkg::csi2_err_ev_t sync_q [`CSI2_SYNC_STAGES];
csi2_stat_pkg::csi2_err_ev_t err_s;
csi2_stat_pkg::csi2_err_stat_t err_stat_q;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      for( int i = 0; i < `CSI2_SYNC_STAGES; i++ )
        sync_q[i] <= '0;
    end
  else
    begin
      sync_q[0] <= err_i;
      for( int i = 1; i < `CSI2_SYNC_STAGES; i++ )
        sync_q[i] <= sync_q[i - 1];
    end

assign err_s = sync_q[`CSI2_SYNC_STAGES - 1];

// One count per high cycle of each synchronized level
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    err_stat_q <= '0;
  else
    if( clear_stat_i )
      err_stat_q <= '0;
    else
      begin
        if( err_s.header_err )
          err_stat_q.header_err_cnt <= err_stat_q.header_err_cnt + 1'b1;

        // A corrected header is only meaningful together with a header error
        if( err_s.header_err && err_s.corr_header_err )
          err_stat_q.corr_header_err_cnt <= err_stat_q.corr_header_err_cnt + 1'b1;

        if( err_s.crc_err )
          err_stat_q.crc_err_cnt <= err_stat_q.crc_err_cnt + 1'b1;
      end

assign err_stat_o = err_stat_q;

endmodule

// ==== hw/csi2_stat_pkg.sv ====
/*
  CSI-2 statistics types.
  Pixel bus beat, receive-side error strobes and the grouped statistic outputs.
*/
`include "csi2_stat_macros.svh"

package csi2_stat_pkg;

  // One beat of the pixel bus
  typedef struct packed {
    logic val;
    logic ready;
    logic eol;
    logic frame_start;
  } csi2_video_ev_t;

  // Error strobes from the packet decoder, receive clock domain
  typedef struct packed {
    logic header_err;
    logic corr_header_err;
    logic crc_err;
  } csi2_err_ev_t;

  // Error counts in the pixel clock domain
  typedef struct packed {
    logic [`CSI2_STAT_W-1:0] header_err_cnt;
    logic [`CSI2_STAT_W-1:0] corr_header_err_cnt;
    logic [`CSI2_STAT_W-1:0] crc_err_cnt;
  } csi2_err_stat_t;

  // Line and frame extremes
  typedef struct packed {
    logic [`CSI2_STAT_W-1:0] max_px_per_ln;
    logic [`CSI2_STAT_W-1:0] min_px_per_ln;
    logic [`CSI2_STAT_W-1:0] max_ln_per_frame;
    logic [`CSI2_STAT_W-1:0] min_ln_per_frame;
  } csi2_geom_stat_t;

endpackage

// ==== include/csi2_stat_macros.svh ====
/*
  CSI-2 statistics block constants.
  Counter width, error strobe synchronizer depth and default reference clock.
*/
`ifndef CSI2_STAT_MACROS_SVH
`define CSI2_STAT_MACROS_SVH

// Width of every counter and statistic
`define CSI2_STAT_W 32

// Flops in each error strobe synchronizer
`define CSI2_SYNC_STAGES 2

// Default pixel clock frequency in Hz, sets the frequency meter gate
`define CSI2_REF_CLK_FREQ 74_250_000

`endif
